//--- hw/soc_pkg.sv
// Shared definitions for the interconnect
// Bus widths and payload types, L2 geometry, memory map,
// control register offsets and the decoder target enum

package soc_pkg;

  //////////////////////////////
  // Widths and types
  //////////////////////////////

  localparam int unsigned ADDR_W     = 32;
  localparam int unsigned DATA_W     = 64;
  localparam int unsigned STRB_W     = DATA_W / 8;
  localparam int unsigned APB_DATA_W = 32;

  typedef logic [ADDR_W-1:0]     addr_t;
  typedef logic [DATA_W-1:0]     data_t;
  typedef logic [STRB_W-1:0]     strb_t;
  typedef logic [APB_DATA_W-1:0] apb_data_t;

  // L2 geometry, one word per bus beat
  localparam int unsigned L2_NUM_WORDS = 1024;
  localparam int unsigned L2_IDX_W     = $clog2(L2_NUM_WORDS);
  localparam int unsigned BYTE_OFFS_W  = $clog2(STRB_W);

  //////////////////////////////
  // Memory map
  //////////////////////////////

  localparam addr_t DRAM_BASE   = 32'h8000_0000;
  localparam addr_t DRAM_LENGTH = 32'h2000;
  localparam addr_t UART_BASE   = 32'hC000_0000;
  localparam addr_t UART_LENGTH = 32'h1000;
  localparam addr_t CTRL_BASE   = 32'hD000_0000;
  localparam addr_t CTRL_LENGTH = 32'h1000;

  // Control register byte offsets
  localparam logic [7:0] CTRL_EXIT_OFFS      = 8'h00;
  localparam logic [7:0] CTRL_DRAM_BASE_OFFS = 8'h08;
  localparam logic [7:0] CTRL_DRAM_END_OFFS  = 8'h10;
  localparam logic [7:0] CTRL_HW_CNT_EN_OFFS = 8'h18;

  typedef enum logic [1:0] {
    TGT_L2,
    TGT_UART,
    TGT_CTRL,
    TGT_NONE
  } target_e;

endpackage

//--- hw/soc_addr_decoder.sv
// Address decoder for the master bus
// Region compare, grant generation, granted-target tracking
// and response multiplexing

`timescale 1ns/10ps

module soc_addr_decoder import soc_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_n_i,
  input  logic    req_i,
  input  addr_t   addr_i,
  output logic    l2_sel_o,
  output logic    uart_sel_o,
  output logic    ctrl_sel_o,
  input  logic    uart_done_i,
  input  data_t   l2_rdata_i,
  input  data_t   uart_rdata_i,
  input  data_t   ctrl_rdata_i,
  input  logic    uart_err_i,
  output logic    gnt_o,
  output logic    rvalid_o,
  output logic    err_o,
  output data_t   rdata_o
);

  target_e tgt_d;
  target_e tgt_q;
  logic    rvalid_q;

  // Region match by base and length
  always_comb begin
    if (addr_i >= DRAM_BASE && addr_i < DRAM_BASE + DRAM_LENGTH) begin
      tgt_d = TGT_L2;
    end else if (addr_i >= UART_BASE && addr_i < UART_BASE + UART_LENGTH) begin
      tgt_d = TGT_UART;
    end else if (addr_i >= CTRL_BASE && addr_i < CTRL_BASE + CTRL_LENGTH) begin
      tgt_d = TGT_CTRL;
    end else begin
      tgt_d = TGT_NONE;
    end
  end

  assign l2_sel_o   = req_i && (tgt_d == TGT_L2);
  assign uart_sel_o = req_i && (tgt_d == TGT_UART);
  assign ctrl_sel_o = req_i && (tgt_d == TGT_CTRL);

  // UART waits for the APB access to finish
  assign gnt_o = req_i && ((tgt_d != TGT_UART) || uart_done_i);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
      tgt_q    <= TGT_NONE;
    end else begin
      rvalid_q <= gnt_o;
      if (gnt_o) begin
        tgt_q <= tgt_d;
      end
    end
  end

  assign rvalid_o = rvalid_q;

  always_comb begin
    case (tgt_q)
      TGT_L2:   rdata_o = l2_rdata_i;
      TGT_UART: rdata_o = uart_rdata_i;
      TGT_CTRL: rdata_o = ctrl_rdata_i;
      default:  rdata_o = '0;
    endcase
  end

  // Unmapped accesses always fail
  assign err_o = rvalid_q &&
                 ((tgt_q == TGT_NONE) || ((tgt_q == TGT_UART) && uart_err_i));

endmodule

//--- hw/l2_sram.sv
// L2 memory, 64-bit words with byte enables
// Read data is registered one cycle after select

`timescale 1ns/10ps

module l2_sram import soc_pkg::*; (
  input  logic  clk_i,
  input  logic  sel_i,
  input  logic  we_i,
  input  addr_t addr_i,
  input  strb_t be_i,
  input  data_t wdata_i,
  output data_t rdata_o
);

  data_t                 mem [L2_NUM_WORDS];
  logic [L2_IDX_W-1:0]   idx;

  // Word index above the byte offset
  assign idx = addr_i[L2_IDX_W+BYTE_OFFS_W-1:BYTE_OFFS_W];

  always_ff @(posedge clk_i) begin
    if (sel_i) begin
      if (we_i) begin
        for (int b = 0; b < STRB_W; b++) begin
          if (be_i[b]) begin
            mem[idx][8*b +: 8] <= wdata_i[8*b +: 8];
          end
        end
        // Writes answer with zero data
        rdata_o <= '0;
      end else begin
        rdata_o <= mem[idx];
      end
    end
  end

endmodule

//--- hw/uart_apb_bridge.sv
// Bus to APB bridge for the UART
// Idle, setup and access FSM, 64-to-32-bit lane selection

`timescale 1ns/10ps

module uart_apb_bridge import soc_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  logic      sel_i,
  input  logic      we_i,
  input  addr_t     addr_i,
  input  data_t     wdata_i,
  output logic      done_o,
  output data_t     rdata_o,
  output logic      err_o,
  output logic      uart_psel_o,
  output logic      uart_penable_o,
  output logic      uart_pwrite_o,
  output addr_t     uart_paddr_o,
  output apb_data_t uart_pwdata_o,
  input  apb_data_t uart_prdata_i,
  input  logic      uart_pready_i,
  input  logic      uart_pslverr_i
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_SETUP,
    ST_ACCESS
  } state_e;

  state_e state_q;
  logic   lane_q;

  assign uart_psel_o    = (state_q != ST_IDLE);
  assign uart_penable_o = (state_q == ST_ACCESS);
  assign done_o         = (state_q == ST_ACCESS) && uart_pready_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= ST_IDLE;
      err_o   <= 1'b0;
    end else begin
      case (state_q)
        ST_IDLE:   if (sel_i) state_q <= ST_SETUP;
        ST_SETUP:  state_q <= ST_ACCESS;
        ST_ACCESS: begin
          if (uart_pready_i) begin
            state_q <= ST_IDLE;
            err_o   <= uart_pslverr_i;
          end
        end
        default:   state_q <= ST_IDLE;
      endcase
    end
  end

  // Request fields, captured when leaving idle
  always_ff @(posedge clk_i) begin
    if (state_q == ST_IDLE && sel_i) begin
      lane_q        <= addr_i[2];
      uart_pwrite_o <= we_i;
      uart_paddr_o  <= addr_i - UART_BASE;
      // Address bit 2 picks the upper word
      uart_pwdata_o <= addr_i[2] ? wdata_i[DATA_W-1:APB_DATA_W] : wdata_i[APB_DATA_W-1:0];
    end
    if (done_o) begin
      if (uart_pwrite_o) begin
        rdata_o <= '0;
      end else if (lane_q) begin
        rdata_o <= {uart_prdata_i, {APB_DATA_W{1'b0}}};
      end else begin
        rdata_o <= {{APB_DATA_W{1'b0}}, uart_prdata_i};
      end
    end
  end

endmodule

//--- hw/soc_ctrl_regs.sv
// Control register block
// Exit and counter-enable registers with byte enables,
// read-only DRAM base and end registers

`timescale 1ns/10ps

module soc_ctrl_regs import soc_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_n_i,
  input  logic  sel_i,
  input  logic  we_i,
  input  addr_t addr_i,
  input  strb_t be_i,
  input  data_t wdata_i,
  output data_t rdata_o,
  output data_t exit_o,
  output data_t hw_cnt_en_o
);

  logic [7:0] offs;
  data_t      dram_base;
  data_t      dram_end;
  logic       exit_we;
  logic       cnt_en_we;

  assign offs      = addr_i[7:0];
  assign dram_base = DATA_W'(DRAM_BASE);
  assign dram_end  = DATA_W'(DRAM_BASE) + DATA_W'(DRAM_LENGTH);

  assign exit_we   = sel_i && we_i && (offs == CTRL_EXIT_OFFS);
  assign cnt_en_we = sel_i && we_i && (offs == CTRL_HW_CNT_EN_OFFS);

  //////////////////////////////
  // Writable registers
  //////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      exit_o      <= '0;
      hw_cnt_en_o <= '0;
    end else begin
      for (int b = 0; b < STRB_W; b++) begin
        if (be_i[b]) begin
          if (exit_we) begin
            exit_o[8*b +: 8] <= wdata_i[8*b +: 8];
          end
          if (cnt_en_we) begin
            hw_cnt_en_o[8*b +: 8] <= wdata_i[8*b +: 8];
          end
        end
      end
    end
  end

  //////////////////////////////
  // Read port
  //////////////////////////////

  always_ff @(posedge clk_i) begin
    if (sel_i) begin
      if (we_i) begin
        rdata_o <= '0;
      end else begin
        case (offs)
          CTRL_EXIT_OFFS:      rdata_o <= exit_o;
          CTRL_DRAM_BASE_OFFS: rdata_o <= dram_base;
          CTRL_DRAM_END_OFFS:  rdata_o <= dram_end;
          CTRL_HW_CNT_EN_OFFS: rdata_o <= hw_cnt_en_o;
          // undefined offsets read as zero
          default:             rdata_o <= '0;
        endcase
      end
    end
  end

endmodule

//--- hw/mini_soc.sv
// Top level of the interconnect
// Address decoder, L2 SRAM, UART APB bridge and control registers

`timescale 1ns/10ps

module mini_soc import soc_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_n_i,
  // Master bus
  input  logic      req_i,
  input  logic      we_i,
  input  addr_t     addr_i,
  input  strb_t     be_i,
  input  data_t     wdata_i,
  output logic      gnt_o,
  output logic      rvalid_o,
  output data_t     rdata_o,
  output logic      err_o,
  // Control outputs
  output data_t     exit_o,
  output data_t     hw_cnt_en_o,
  // UART APB
  output logic      uart_psel_o,
  output logic      uart_penable_o,
  output logic      uart_pwrite_o,
  output addr_t     uart_paddr_o,
  output apb_data_t uart_pwdata_o,
  input  apb_data_t uart_prdata_i,
  input  logic      uart_pready_i,
  input  logic      uart_pslverr_i
);

  logic  l2_sel;
  logic  uart_sel;
  logic  ctrl_sel;
  logic  uart_done;
  logic  uart_err;
  data_t l2_rdata;
  data_t uart_rdata;
  data_t ctrl_rdata;

  //////////////////////////////
  // Decoder
  //////////////////////////////

  soc_addr_decoder i_decoder (
    .clk_i       (clk_i     ),
    .rst_n_i     (rst_n_i   ),
    .req_i       (req_i     ),
    .addr_i      (addr_i    ),
    .l2_sel_o    (l2_sel    ),
    .uart_sel_o  (uart_sel  ),
    .ctrl_sel_o  (ctrl_sel  ),
    .uart_done_i (uart_done ),
    .l2_rdata_i  (l2_rdata  ),
    .uart_rdata_i(uart_rdata),
    .ctrl_rdata_i(ctrl_rdata),
    .uart_err_i  (uart_err  ),
    .gnt_o       (gnt_o     ),
    .rvalid_o    (rvalid_o  ),
    .err_o       (err_o     ),
    .rdata_o     (rdata_o   )
  );

  //////////////////////////////
  // Targets
  //////////////////////////////

  l2_sram i_l2 (
    .clk_i  (clk_i   ),
    .sel_i  (l2_sel  ),
    .we_i   (we_i    ),
    .addr_i (addr_i  ),
    .be_i   (be_i    ),
    .wdata_i(wdata_i ),
    .rdata_o(l2_rdata)
  );

  uart_apb_bridge i_uart_bridge (
    .clk_i         (clk_i         ),
    .rst_n_i       (rst_n_i       ),
    .sel_i         (uart_sel      ),
    .we_i          (we_i          ),
    .addr_i        (addr_i        ),
    .wdata_i       (wdata_i       ),
    .done_o        (uart_done     ),
    .rdata_o       (uart_rdata    ),
    .err_o         (uart_err      ),
    .uart_psel_o   (uart_psel_o   ),
    .uart_penable_o(uart_penable_o),
    .uart_pwrite_o (uart_pwrite_o ),
    .uart_paddr_o  (uart_paddr_o  ),
    .uart_pwdata_o (uart_pwdata_o ),
    .uart_prdata_i (uart_prdata_i ),
    .uart_pready_i (uart_pready_i ),
    .uart_pslverr_i(uart_pslverr_i)
  );

  soc_ctrl_regs i_ctrl_regs (
    .clk_i      (clk_i      ),
    .rst_n_i    (rst_n_i    ),
    .sel_i      (ctrl_sel   ),
    .we_i       (we_i       ),
    .addr_i     (addr_i     ),
    .be_i       (be_i       ),
    .wdata_i    (wdata_i    ),
    .rdata_o    (ctrl_rdata ),
    .exit_o     (exit_o     ),
    .hw_cnt_en_o(hw_cnt_en_o)
  );

endmodule

//--- testbench/mini_soc_assertions.sv
// Concurrent checks on master bus and APB timing
// Bound to the top level

`timescale 1ns/10ps

module mini_soc_assertions (
  input logic clk_i,
  input logic rst_n_i,
  input logic req_i,
  input logic gnt_o,
  input logic rvalid_o,
  input logic uart_psel_o,
  input logic uart_penable_o,
  input logic uart_pready_i
);

  int unsigned fail_count;

  initial fail_count = 0;

  // A grant during an APB transfer only ends its access phase
  gnt_needs_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    gnt_o |-> req_i && (!uart_psel_o || (uart_penable_o && uart_pready_i)))
    else begin
      $error("gnt_o high without req_i or before the APB access completed");
      fail_count++;
    end

  rvalid_after_gnt: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    gnt_o |=> rvalid_o)
    else begin
      $error("rvalid_o missing one cycle after gnt_o");
      fail_count++;
    end

  rvalid_only_after_gnt: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rvalid_o |-> $past(gnt_o))
    else begin
      $error("rvalid_o without a grant in the previous cycle");
      fail_count++;
    end

  // Access phase always follows a setup phase
  penable_needs_psel: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    uart_penable_o |-> uart_psel_o && $past(uart_psel_o))
    else begin
      $error("uart_penable_o high without uart_psel_o or a setup phase");
      fail_count++;
    end

  // APB transfer may only end on pready
  psel_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    uart_psel_o && !(uart_penable_o && uart_pready_i) |=> uart_psel_o)
    else begin
      $error("uart_psel_o dropped before uart_pready_i");
      fail_count++;
    end

  quiet_after_reset: assert property (@(posedge clk_i)
    $rose(rst_n_i) |-> !gnt_o && !uart_psel_o)
    else begin
      $error("grant or psel in the first cycle after reset");
      fail_count++;
    end

endmodule

bind mini_soc mini_soc_assertions i_assertions (
  .clk_i         (clk_i         ),
  .rst_n_i       (rst_n_i       ),
  .req_i         (req_i         ),
  .gnt_o         (gnt_o         ),
  .rvalid_o      (rvalid_o      ),
  .uart_psel_o   (uart_psel_o   ),
  .uart_penable_o(uart_penable_o),
  .uart_pready_i (uart_pready_i )
);

//--- testbench/tb_mini_soc.sv
// Testbench for the interconnect top level
// Clock and reset, APB slave model, L2 shadow model,
// directed tests for reset, L2, control registers, UART and unmapped space

`timescale 1ns/10ps

module tb_mini_soc import soc_pkg::*; ();

  localparam int          CLK_PERIOD    = 40;
  localparam int          GNT_TIMEOUT   = 20;
  localparam int          APB_MAX_WAITS = 3;
  localparam int          L2_TEST_WORDS = 8;
  localparam int unsigned SEED          = 32'h94804ac4;

  logic      clk;
  logic      rst_n;
  logic      req;
  logic      we;
  addr_t     addr;
  strb_t     be;
  data_t     wdata;
  logic      gnt;
  logic      rvalid;
  data_t     rdata;
  logic      err;
  data_t     exit_val;
  data_t     hw_cnt_en;
  logic      psel;
  logic      penable;
  logic      pwrite;
  addr_t     paddr;
  apb_data_t pwdata;
  apb_data_t prdata;
  logic      pready;
  logic      pslverr;

  // APB slave model state
  apb_data_t apb_regs [16];
  int        apb_wait_cnt;
  int        apb_waits;
  logic      slverr_en;
  addr_t     seen_paddr;
  apb_data_t seen_pwdata;
  logic      seen_pwrite;

  data_t     l2_shadow [L2_NUM_WORDS];
  int        l2_idx_q [$];
  data_t     exp_exit;
  data_t     exp_cnt_en;
  int        errors;
  int        checks;

  mini_soc i_mini_soc (
    .clk_i         (clk      ),
    .rst_n_i       (rst_n    ),
    .req_i         (req      ),
    .we_i          (we       ),
    .addr_i        (addr     ),
    .be_i          (be       ),
    .wdata_i       (wdata    ),
    .gnt_o         (gnt      ),
    .rvalid_o      (rvalid   ),
    .rdata_o       (rdata    ),
    .err_o         (err      ),
    .exit_o        (exit_val ),
    .hw_cnt_en_o   (hw_cnt_en),
    .uart_psel_o   (psel     ),
    .uart_penable_o(penable  ),
    .uart_pwrite_o (pwrite   ),
    .uart_paddr_o  (paddr    ),
    .uart_pwdata_o (pwdata   ),
    .uart_prdata_i (prdata   ),
    .uart_pready_i (pready   ),
    .uart_pslverr_i(pslverr  )
  );

  always #(CLK_PERIOD/2) clk = ~clk;

  //////////////////////////////
  // APB slave model
  //////////////////////////////

  always @(negedge clk) begin : apb_slave
    int pick;
    if (!psel) begin
      pready  <= 1'b0;
      pslverr <= 1'b0;
    end else if (!penable) begin
      // Setup phase, choose the wait states for this transfer
      pick = int'($urandom % (APB_MAX_WAITS + 1));
      apb_wait_cnt <= pick;
      apb_waits    <= pick;
      seen_paddr   <= paddr;
      seen_pwdata  <= pwdata;
      seen_pwrite  <= pwrite;
      pready       <= 1'b0;
    end else if (!pready) begin
      if (apb_wait_cnt == 0) begin
        pready  <= 1'b1;
        pslverr <= slverr_en;
        if (pwrite) begin
          apb_regs[paddr[5:2]] <= pwdata;
        end else begin
          prdata <= apb_regs[paddr[5:2]];
        end
      end else begin
        apb_wait_cnt <= apb_wait_cnt - 1;
      end
    end
  end

  //////////////////////////////
  // Helpers
  //////////////////////////////

  task automatic compare(input string name, input logic [63:0] actual,
                         input logic [63:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("CHECK FAILED at %0t ns: %s = 0x%h, expected 0x%h",
               $time, name, actual, expected);
    end
  endtask

  function automatic data_t merge_bytes(input data_t old_val, input data_t new_val,
                                        input strb_t en);
    data_t res;
    res = old_val;
    for (int b = 0; b < STRB_W; b++) begin
      if (en[b]) res[8*b +: 8] = new_val[8*b +: 8];
    end
    return res;
  endfunction

  // One request, held until granted, then its response
  task automatic bus_access(input logic wr, input addr_t a, input strb_t en, input data_t wd,
                            output data_t rd, output logic er, output int cycles);
    logic granted;
    @(negedge clk);
    req    = 1'b1;
    we     = wr;
    addr   = a;
    be     = en;
    wdata  = wd;
    cycles = 0;
    #1;
    granted = gnt;
    while (!granted && cycles < GNT_TIMEOUT) begin
      @(negedge clk);
      #1;
      cycles++;
      granted = gnt;
    end
    @(negedge clk);
    req = 1'b0;
    if (!granted) begin
      errors++;
      $display("Timeout: no grant for address 0x%h within %0d cycles", a, GNT_TIMEOUT);
      rd = '0;
      er = 1'b0;
    end else begin
      #1;
      compare("rvalid_o", rvalid, 1'b1);
      rd = rdata;
      er = err;
    end
  endtask

  // Pipelined reads, one new request per cycle
  task automatic l2_read_burst();
    int n;
    n = l2_idx_q.size();
    for (int k = 0; k <= n; k++) begin
      @(negedge clk);
      if (k < n) begin
        req  = 1'b1;
        we   = 1'b0;
        be   = '1;
        addr = DRAM_BASE + addr_t'(l2_idx_q[k] * STRB_W);
      end else begin
        req = 1'b0;
      end
      #1;
      if (k < n) compare("gnt_o", gnt, 1'b1);
      if (k > 0) begin
        compare("rvalid_o", rvalid, 1'b1);
        compare("rdata_o", rdata, l2_shadow[l2_idx_q[k-1]]);
        compare("err_o", err, 1'b0);
      end
    end
  endtask

  //////////////////////////////
  // Tests
  //////////////////////////////

  task automatic test_reset();
    int start;
    start = errors;
    @(negedge clk);
    #1;
    compare("gnt_o", gnt, 1'b0);
    compare("rvalid_o", rvalid, 1'b0);
    compare("err_o", err, 1'b0);
    compare("uart_psel_o", psel, 1'b0);
    compare("uart_penable_o", penable, 1'b0);
    compare("exit_o", exit_val, '0);
    compare("hw_cnt_en_o", hw_cnt_en, '0);
    $display("Test reset_state finished with %0d errors", errors - start);
  endtask

  task automatic test_l2();
    int    start;
    int    idx;
    strb_t en;
    data_t wd;
    data_t rd;
    logic  er;
    int    cycles;
    start = errors;
    l2_idx_q.delete();
    l2_idx_q.push_back(0);
    for (int k = 1; k < L2_TEST_WORDS; k++) begin
      l2_idx_q.push_back(int'($urandom % L2_NUM_WORDS));
    end
    foreach (l2_idx_q[k]) begin
      idx = l2_idx_q[k];
      wd  = {$urandom, $urandom};
      bus_access(1'b1, DRAM_BASE + addr_t'(idx * STRB_W), '1, wd, rd, er, cycles);
      l2_shadow[idx] = wd;
      compare("gnt_o latency", cycles, 0);
      compare("rdata_o", rd, '0);
      compare("err_o", er, 1'b0);
      // Partial overwrite with random byte enables
      en = strb_t'($urandom);
      wd = {$urandom, $urandom};
      bus_access(1'b1, DRAM_BASE + addr_t'(idx * STRB_W), en, wd, rd, er, cycles);
      l2_shadow[idx] = merge_bytes(l2_shadow[idx], wd, en);
      compare("gnt_o latency", cycles, 0);
    end
    l2_read_burst();
    $display("Test l2_memory finished with %0d errors", errors - start);
  endtask

  task automatic test_ctrl();
    int    start;
    strb_t en;
    data_t wd;
    data_t rd;
    logic  er;
    int    cycles;
    data_t dram_end;
    start    = errors;
    dram_end = {32'h0, DRAM_BASE} + {32'h0, DRAM_LENGTH};
    bus_access(1'b0, CTRL_BASE + addr_t'(CTRL_DRAM_BASE_OFFS), '1, '0, rd, er, cycles);
    compare("rdata_o dram base", rd, {32'h0, DRAM_BASE});
    compare("gnt_o latency", cycles, 0);
    bus_access(1'b0, CTRL_BASE + addr_t'(CTRL_DRAM_END_OFFS), '1, '0, rd, er, cycles);
    compare("rdata_o dram end", rd, dram_end);
    for (int k = 0; k < 2; k++) begin
      en = (k == 0) ? 8'h0F : strb_t'($urandom);
      wd = {$urandom, $urandom};
      bus_access(1'b1, CTRL_BASE + addr_t'(CTRL_EXIT_OFFS), en, wd, rd, er, cycles);
      exp_exit = merge_bytes(exp_exit, wd, en);
      compare("exit_o", exit_val, exp_exit);
      en = (k == 0) ? 8'hFF : strb_t'($urandom);
      wd = {$urandom, $urandom};
      bus_access(1'b1, CTRL_BASE + addr_t'(CTRL_HW_CNT_EN_OFFS), en, wd, rd, er, cycles);
      exp_cnt_en = merge_bytes(exp_cnt_en, wd, en);
      compare("hw_cnt_en_o", hw_cnt_en, exp_cnt_en);
    end
    bus_access(1'b0, CTRL_BASE + addr_t'(CTRL_EXIT_OFFS), '1, '0, rd, er, cycles);
    compare("rdata_o exit", rd, exp_exit);
    // Read-only registers ignore writes
    bus_access(1'b1, CTRL_BASE + addr_t'(CTRL_DRAM_BASE_OFFS), '1, '1, rd, er, cycles);
    bus_access(1'b1, CTRL_BASE + addr_t'(CTRL_DRAM_END_OFFS), '1, '1, rd, er, cycles);
    bus_access(1'b0, CTRL_BASE + addr_t'(CTRL_DRAM_BASE_OFFS), '1, '0, rd, er, cycles);
    compare("rdata_o dram base", rd, {32'h0, DRAM_BASE});
    bus_access(1'b0, CTRL_BASE + addr_t'(CTRL_DRAM_END_OFFS), '1, '0, rd, er, cycles);
    compare("rdata_o dram end", rd, dram_end);
    compare("exit_o", exit_val, exp_exit);
    compare("hw_cnt_en_o", hw_cnt_en, exp_cnt_en);
    $display("Test ctrl_regs finished with %0d errors", errors - start);
  endtask

  task automatic test_uart();
    int        start;
    addr_t     offs_list [4] = '{32'h0, 32'h4, 32'h10, 32'h2C};
    addr_t     offs;
    apb_data_t lane;
    data_t     wd;
    data_t     rd;
    logic      er;
    int        cycles;
    start = errors;
    foreach (offs_list[k]) begin
      offs = offs_list[k];
      wd   = {$urandom, $urandom};
      lane = offs[2] ? wd[63:32] : wd[31:0];
      bus_access(1'b1, UART_BASE + offs, '1, wd, rd, er, cycles);
      compare("gnt_o latency", cycles, 2 + apb_waits);
      compare("uart_paddr_o", seen_paddr, offs);
      compare("uart_pwdata_o", seen_pwdata, lane);
      compare("uart_pwrite_o", seen_pwrite, 1'b1);
      compare("rdata_o", rd, '0);
      compare("err_o", er, 1'b0);
      bus_access(1'b0, UART_BASE + offs, '1, '0, rd, er, cycles);
      compare("gnt_o latency", cycles, 2 + apb_waits);
      compare("uart_paddr_o", seen_paddr, offs);
      compare("uart_pwrite_o", seen_pwrite, 1'b0);
      compare("rdata_o", rd, offs[2] ? {lane, 32'h0} : {32'h0, lane});
      compare("err_o", er, 1'b0);
    end
    slverr_en = 1'b1;
    bus_access(1'b0, UART_BASE + 32'h8, '1, '0, rd, er, cycles);
    compare("err_o on pslverr", er, 1'b1);
    slverr_en = 1'b0;
    $display("Test uart_bridge finished with %0d errors", errors - start);
  endtask

  task automatic test_unmapped();
    int    start;
    addr_t bad_addr [4];
    data_t rd;
    logic  er;
    int    cycles;
    start = errors;
    bad_addr[0] = 32'h0000_1000;
    bad_addr[1] = DRAM_BASE + DRAM_LENGTH;
    bad_addr[2] = UART_BASE + UART_LENGTH;
    bad_addr[3] = CTRL_BASE + CTRL_LENGTH;
    foreach (bad_addr[k]) begin
      bus_access(1'b1, bad_addr[k], '1, {$urandom, $urandom}, rd, er, cycles);
      compare("gnt_o latency", cycles, 0);
      compare("err_o", er, 1'b1);
      compare("rdata_o", rd, '0);
      bus_access(1'b0, bad_addr[k], '1, '0, rd, er, cycles);
      compare("gnt_o latency", cycles, 0);
      compare("err_o", er, 1'b1);
      compare("rdata_o", rd, '0);
    end
    compare("exit_o", exit_val, exp_exit);
    compare("hw_cnt_en_o", hw_cnt_en, exp_cnt_en);
    bus_access(1'b0, DRAM_BASE, '1, '0, rd, er, cycles);
    compare("rdata_o l2 word 0", rd, l2_shadow[0]);
    compare("err_o", er, 1'b0);
    $display("Test unmapped finished with %0d errors", errors - start);
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    int fails;
    void'($urandom(SEED));
    clk          = 1'b0;
    rst_n        = 1'b0;
    req          = 1'b0;
    we           = 1'b0;
    addr         = '0;
    be           = '0;
    wdata        = '0;
    prdata       = '0;
    pready       = 1'b0;
    pslverr      = 1'b0;
    slverr_en    = 1'b0;
    apb_wait_cnt = 0;
    apb_waits    = 0;
    exp_exit     = '0;
    exp_cnt_en   = '0;
    errors       = 0;
    checks       = 0;
    foreach (apb_regs[i]) begin
      apb_regs[i] = {16'hA5A5, 16'(i)};
    end
    repeat (5) @(negedge clk);
    rst_n = 1'b1;

    test_reset();
    test_l2();
    test_ctrl();
    test_uart();
    test_unmapped();

    fails = errors + int'(i_mini_soc.i_assertions.fail_count);
    $display("Checks: %0d, errors: %0d, assertion failures: %0d",
             checks, errors, i_mini_soc.i_assertions.fail_count);
    if (fails == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

//--- all.f
hw/soc_pkg.sv
hw/soc_addr_decoder.sv
hw/l2_sram.sv
hw/uart_apb_bridge.sv
hw/soc_ctrl_regs.sv
hw/mini_soc.sv
testbench/mini_soc_assertions.sv
testbench/tb_mini_soc.sv

//--- Bender.yml
package:
  name: mini_soc

sources:
  - hw/soc_pkg.sv
  - hw/soc_addr_decoder.sv
  - hw/l2_sram.sv
  - hw/uart_apb_bridge.sv
  - hw/soc_ctrl_regs.sv
  - hw/mini_soc.sv
  - target: test
    files:
      - testbench/mini_soc_assertions.sv
      - testbench/tb_mini_soc.sv
